// File: include/alu_consts.svh
/* ALU constants
   data and opcode widths, plus the sign and carry bit positions */

`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// width of the a and b operands and of the result
`define ALU_WIDTH 8

// width of the opcode that selects one of the 32 table entries
`define ALU_OP_WIDTH 5

// index of the sign bit in a two's complement operand or result
`define ALU_SIGN_BIT 7

// index of the carry bit in the widened 9-bit arithmetic result
`define ALU_CARRY_BIT 8

`endif

// File: src/alu_pkg.sv
/* ALU types
   opcode table, unit and sub-operation selects, and the unit result record */

`include "alu_consts.svh"

package alu_pkg;

    // full opcode table, numbered as in the CPU microcode
    // divide, modulo, asr, rotates and bcd are listed but not implemented
    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        op_zero                = 5'd0,
        op_a                   = 5'd1,
        op_b                   = 5'd2,
        op_negate_a            = 5'd3,
        op_negate_b            = 5'd4,
        op_a_plus_1            = 5'd5,
        op_b_plus_1            = 5'd6,
        op_a_minus_1           = 5'd7,
        op_b_minus_1           = 5'd8,
        op_a_plus_b            = 5'd9,
        op_a_minus_b           = 5'd10,
        op_b_minus_a           = 5'd11,
        op_a_minus_b_signedmag = 5'd12,
        op_a_plus_b_plus_c     = 5'd13,
        op_a_minus_b_minus_c   = 5'd14,
        op_b_minus_a_minus_c   = 5'd15,
        op_a_times_b_lo        = 5'd16,
        op_a_times_b_hi        = 5'd17,
        op_a_div_b             = 5'd18,
        op_a_mod_b             = 5'd19,
        op_a_lsl_b             = 5'd20,
        op_a_lsr_b             = 5'd21,
        op_a_asr_b             = 5'd22,
        op_a_rol_b             = 5'd23,
        op_a_ror_b             = 5'd24,
        op_a_and_b             = 5'd25,
        op_a_or_b              = 5'd26,
        op_a_xor_b             = 5'd27,
        op_not_a               = 5'd28,
        op_not_b               = 5'd29,
        op_a_plus_b_bcd        = 5'd30,
        op_a_minus_b_bcd       = 5'd31
    } alu_op_t;

    // which datapath unit feeds the output register
    // unit_none gives a zero result with carry and overflow clear,
    // which is also how the constant zero opcode is produced
    typedef enum logic [1:0] {
        unit_none        = 2'd0,
        unit_arith       = 2'd1,
        unit_shift_logic = 2'd2
    } alu_unit_t;

    // arithmetic sub-operations, the *_one forms subtract or add one extra
    typedef enum logic [3:0] {
        arith_pass_a, arith_pass_b,
        arith_neg_a, arith_neg_b,
        arith_inc_a, arith_inc_b,
        arith_dec_a, arith_dec_b,
        arith_add, arith_add_one,
        arith_a_sub_b, arith_a_sub_b_one,
        arith_b_sub_a, arith_b_sub_a_one,
        arith_mul_lo, arith_mul_hi
    } arith_op_t;

    // shift and bitwise sub-operations
    typedef enum logic [2:0] {
        sl_lsl, sl_lsr, sl_and, sl_or, sl_xor, sl_not_a, sl_not_b
    } shift_logic_op_t;

    // what each unit hands back, carry and overflow are active high here
    typedef struct packed {
        logic [`ALU_WIDTH-1:0] value;
        logic                  carry;
        logic                  overflow;
    } unit_result_t;

endpackage

// File: src/alu_unit_if.sv
/* operand and decode bundle
   carries the registered operands and decoded selects to the datapath units */

`include "alu_consts.svh"

interface alu_unit_if import alu_pkg::*; ();

    // operands as captured by the input register stage
    logic [`ALU_WIDTH-1:0] a;
    logic [`ALU_WIDTH-1:0] b;

    // decoded selects, valid in the same cycle as the operands
    arith_op_t             arith_op;
    shift_logic_op_t       shift_logic_op;
    alu_unit_t             unit_sel;
    logic                  signed_cmp;

    modport control (output a, b, arith_op, shift_logic_op, unit_sel, signed_cmp);

    modport arith (input a, b, arith_op);

    modport shift_logic (input a, b, shift_logic_op);

    // the result stage needs the operands for the compare flags
    modport result (input a, b, unit_sel, signed_cmp);

endinterface

// File: src/alu_control.sv
/* ALU input stage
   registers the operands and decodes the opcode and carry-in into unit selects */

`include "alu_consts.svh"

module alu_control import alu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`ALU_WIDTH-1:0] a,
    input  logic [`ALU_WIDTH-1:0] b,
    input  alu_op_t               alu_op,
    input  logic                  carry_in_n,
    alu_unit_if.control           unit
);

    alu_op_t         eff_op;
    alu_unit_t       unit_sel_d;
    arith_op_t       arith_op_d;
    shift_logic_op_t shift_logic_op_d;
    logic            signed_cmp_d;

    // with no carry pending the carry-consuming ops fall back to the plain ones
    always_comb begin
        eff_op = alu_op;
        if (carry_in_n) begin
            case (alu_op)
                op_a_plus_b_plus_c:   eff_op = op_a_plus_b;
                op_a_minus_b_minus_c: eff_op = op_a_minus_b;
                op_b_minus_a_minus_c: eff_op = op_b_minus_a;
                default:              eff_op = alu_op;
            endcase
        end
    end

    // unit select, anything not implemented lands on unit_none
    always_comb begin
        case (eff_op)
            op_a, op_b, op_negate_a, op_negate_b,
            op_a_plus_1, op_b_plus_1, op_a_minus_1, op_b_minus_1,
            op_a_plus_b, op_a_minus_b, op_b_minus_a, op_a_minus_b_signedmag,
            op_a_plus_b_plus_c, op_a_minus_b_minus_c, op_b_minus_a_minus_c,
            op_a_times_b_lo, op_a_times_b_hi:
                unit_sel_d = unit_arith;
            op_a_lsl_b, op_a_lsr_b, op_a_and_b, op_a_or_b,
            op_a_xor_b, op_not_a, op_not_b:
                unit_sel_d = unit_shift_logic;
            default:
                unit_sel_d = unit_none;
        endcase
    end

    // arithmetic sub-op, only meaningful when unit_sel_d is unit_arith
    always_comb begin
        case (eff_op)
            op_b:                   arith_op_d = arith_pass_b;
            op_negate_a:            arith_op_d = arith_neg_a;
            op_negate_b:            arith_op_d = arith_neg_b;
            op_a_plus_1:            arith_op_d = arith_inc_a;
            op_b_plus_1:            arith_op_d = arith_inc_b;
            op_a_minus_1:           arith_op_d = arith_dec_a;
            op_b_minus_1:           arith_op_d = arith_dec_b;
            op_a_plus_b:            arith_op_d = arith_add;
            op_a_minus_b:           arith_op_d = arith_a_sub_b;
            op_b_minus_a:           arith_op_d = arith_b_sub_a;
            op_a_minus_b_signedmag: arith_op_d = arith_a_sub_b;
            op_a_plus_b_plus_c:     arith_op_d = arith_add_one;
            op_a_minus_b_minus_c:   arith_op_d = arith_a_sub_b_one;
            op_b_minus_a_minus_c:   arith_op_d = arith_b_sub_a_one;
            op_a_times_b_lo:        arith_op_d = arith_mul_lo;
            op_a_times_b_hi:        arith_op_d = arith_mul_hi;
            default:                arith_op_d = arith_pass_a;
        endcase
    end

    // shift and logic sub-op
    always_comb begin
        case (eff_op)
            op_a_lsl_b: shift_logic_op_d = sl_lsl;
            op_a_lsr_b: shift_logic_op_d = sl_lsr;
            op_a_or_b:  shift_logic_op_d = sl_or;
            op_a_xor_b: shift_logic_op_d = sl_xor;
            op_not_a:   shift_logic_op_d = sl_not_a;
            op_not_b:   shift_logic_op_d = sl_not_b;
            default:    shift_logic_op_d = sl_and;
        endcase
    end

    // only the signed-magnitude subtract switches the compares to signed
    assign signed_cmp_d = (eff_op == op_a_minus_b_signedmag);

    always_ff @(posedge clk) begin
        if (reset) begin
            unit.a              <= '0;
            unit.b              <= '0;
            unit.unit_sel       <= unit_none;
            unit.arith_op       <= arith_pass_a;
            unit.shift_logic_op <= sl_and;
            unit.signed_cmp     <= 1'b0;
        end else begin
            unit.a              <= a;
            unit.b              <= b;
            unit.unit_sel       <= unit_sel_d;
            unit.arith_op       <= arith_op_d;
            unit.shift_logic_op <= shift_logic_op_d;
            unit.signed_cmp     <= signed_cmp_d;
        end
    end

endmodule

// File: src/alu_arith.sv
/* arithmetic unit
   add, subtract, negate, increment, decrement and multiply with carry and overflow */

`include "alu_consts.svh"

module alu_arith import alu_pkg::*; (
    alu_unit_if.arith    unit,
    output unit_result_t res
);

    // one spare bit above the data holds carry, or borrow for subtraction
    logic [`ALU_WIDTH:0]     a_ext;
    logic [`ALU_WIDTH:0]     b_ext;
    logic [`ALU_WIDTH:0]     wide;
    logic [2*`ALU_WIDTH-1:0] product;
    logic                    sign_a;
    logic                    sign_b;
    logic                    sign_r;
    logic                    ov_add;
    logic                    ov_a_sub_b;
    logic                    ov_b_sub_a;

    assign a_ext   = {1'b0, unit.a};
    assign b_ext   = {1'b0, unit.b};
    assign product = unit.a * unit.b;

    always_comb begin
        case (unit.arith_op)
            arith_pass_a:      wide = a_ext;
            arith_pass_b:      wide = b_ext;
            // 0 - x, so any non-zero operand leaves a borrow in the top bit
            arith_neg_a:       wide = '0 - a_ext;
            arith_neg_b:       wide = '0 - b_ext;
            arith_inc_a:       wide = a_ext + 1'b1;
            arith_inc_b:       wide = b_ext + 1'b1;
            arith_dec_a:       wide = a_ext - 1'b1;
            arith_dec_b:       wide = b_ext - 1'b1;
            arith_add:         wide = a_ext + b_ext;
            arith_add_one:     wide = a_ext + b_ext + 1'b1;
            arith_a_sub_b:     wide = a_ext - b_ext;
            arith_a_sub_b_one: wide = a_ext - b_ext - 1'b1;
            arith_b_sub_a:     wide = b_ext - a_ext;
            arith_b_sub_a_one: wide = b_ext - a_ext - 1'b1;
            // low byte flags a carry whenever the high byte holds anything
            arith_mul_lo:      wide = {|product[2*`ALU_WIDTH-1:`ALU_WIDTH],
                                       product[`ALU_WIDTH-1:0]};
            arith_mul_hi:      wide = {1'b0, product[2*`ALU_WIDTH-1:`ALU_WIDTH]};
            default:           wide = '0;
        endcase
    end

    assign sign_a = unit.a[`ALU_SIGN_BIT];
    assign sign_b = unit.b[`ALU_SIGN_BIT];
    assign sign_r = wide[`ALU_SIGN_BIT];

    // adding like signs must not flip the sign of the result
    assign ov_add = (sign_a == sign_b) && (sign_r != sign_a);

    // subtracting unlike signs must keep the minuend's sign
    assign ov_a_sub_b = (sign_a != sign_b) && (sign_r != sign_a);
    assign ov_b_sub_a = (sign_a != sign_b) && (sign_r != sign_b);

    always_comb begin
        case (unit.arith_op)
            arith_add, arith_add_one:         res.overflow = ov_add;
            arith_a_sub_b, arith_a_sub_b_one: res.overflow = ov_a_sub_b;
            arith_b_sub_a, arith_b_sub_a_one: res.overflow = ov_b_sub_a;
            default:                          res.overflow = 1'b0;
        endcase
    end

    assign res.value = wide[`ALU_WIDTH-1:0];
    assign res.carry = wide[`ALU_CARRY_BIT];

endmodule

// File: src/alu_shift_logic.sv
/* shift and logic unit
   logical shifts by b with shifted-out carry, plus the bitwise operations */

`include "alu_consts.svh"

module alu_shift_logic import alu_pkg::*; (
    alu_unit_if.shift_logic unit,
    output unit_result_t    res
);

    // a sits in a 9-bit field so the last bit pushed out lands next to it
    logic [`ALU_WIDTH:0] lsl_field;
    logic [`ALU_WIDTH:0] lsr_field;

    // shifting by 9 or more clears the whole field, carry included
    assign lsl_field = {1'b0, unit.a} << unit.b;

    // for right shifts the guard bit sits below a and catches bit b-1
    assign lsr_field = {unit.a, 1'b0} >> unit.b;

    always_comb begin
        res.carry = 1'b0;
        case (unit.shift_logic_op)
            sl_lsl: begin
                res.value = lsl_field[`ALU_WIDTH-1:0];
                res.carry = lsl_field[`ALU_WIDTH];
            end
            sl_lsr: begin
                res.value = lsr_field[`ALU_WIDTH:1];
                res.carry = lsr_field[0];
            end
            sl_and:   res.value = unit.a & unit.b;
            sl_or:    res.value = unit.a | unit.b;
            sl_xor:   res.value = unit.a ^ unit.b;
            sl_not_a: res.value = ~unit.a;
            sl_not_b: res.value = ~unit.b;
            default:  res.value = '0;
        endcase
    end

    // nothing here is signed arithmetic, so no overflow
    assign res.overflow = 1'b0;

endmodule

// File: src/alu_result_stage.sv
/* ALU output stage
   picks the unit result, forms status and compare flags, registers them active low */

`include "alu_consts.svh"

module alu_result_stage import alu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    alu_unit_if.result            unit,
    input  unit_result_t          arith_res,
    input  unit_result_t          shift_logic_res,
    output logic [`ALU_WIDTH-1:0] result,
    output logic                  flag_c_n,
    output logic                  flag_z_n,
    output logic                  flag_n_n,
    output logic                  flag_o_n,
    output logic                  flag_gt_n,
    output logic                  flag_lt_n,
    output logic                  flag_eq_n,
    output logic                  flag_ne_n
);

    unit_result_t sel;
    logic         gt;
    logic         lt;

    // unused or unimplemented opcodes read as zero with no carry or overflow
    always_comb begin
        case (unit.unit_sel)
            unit_arith:       sel = arith_res;
            unit_shift_logic: sel = shift_logic_res;
            default:          sel = '0;
        endcase
    end

    // magnitude compare of the operands, not of the result
    assign gt = unit.signed_cmp ? ($signed(unit.a) > $signed(unit.b)) : (unit.a > unit.b);
    assign lt = unit.signed_cmp ? ($signed(unit.a) < $signed(unit.b)) : (unit.a < unit.b);

    // all flags leave the core active low, reset leaves them inactive
    always_ff @(posedge clk) begin
        if (reset) begin
            result    <= '0;
            flag_c_n  <= 1'b1;
            flag_z_n  <= 1'b1;
            flag_n_n  <= 1'b1;
            flag_o_n  <= 1'b1;
            flag_gt_n <= 1'b1;
            flag_lt_n <= 1'b1;
            flag_eq_n <= 1'b1;
            flag_ne_n <= 1'b1;
        end else begin
            result    <= sel.value;
            flag_c_n  <= ~sel.carry;
            flag_z_n  <= ~(sel.value == '0);
            flag_n_n  <= ~sel.value[`ALU_SIGN_BIT];
            flag_o_n  <= ~sel.overflow;
            flag_gt_n <= ~gt;
            flag_lt_n <= ~lt;
            flag_eq_n <= ~(unit.a == unit.b);
            flag_ne_n <= ~(unit.a != unit.b);
        end
    end

endmodule

// File: src/alu_top.sv
/* pipelined 8-bit ALU core
   input register, arithmetic and shift-logic units, registered result and flags */

`include "alu_consts.svh"

module alu_top import alu_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`ALU_WIDTH-1:0]    a,
    input  logic [`ALU_WIDTH-1:0]    b,
    input  logic [`ALU_OP_WIDTH-1:0] alu_op,
    input  logic                     carry_in_n,
    output logic [`ALU_WIDTH-1:0]    result,
    output logic                     flag_c_n,
    output logic                     flag_z_n,
    output logic                     flag_n_n,
    output logic                     flag_o_n,
    output logic                     flag_gt_n,
    output logic                     flag_lt_n,
    output logic                     flag_eq_n,
    output logic                     flag_ne_n
);

    // registered operands and decoded selects shared by both units
    alu_unit_if unit_bus ();

    unit_result_t arith_res;
    unit_result_t shift_logic_res;

    // stage 1 captures the operation at the clock edge
    alu_control control_i (
        .clk        (clk),
        .reset      (reset),
        .a          (a),
        .b          (b),
        .alu_op     (alu_op_t'(alu_op)),
        .carry_in_n (carry_in_n),
        .unit       (unit_bus.control)
    );

    alu_arith arith_i (
        .unit (unit_bus.arith),
        .res  (arith_res)
    );

    alu_shift_logic shift_logic_i (
        .unit (unit_bus.shift_logic),
        .res  (shift_logic_res)
    );

    // stage 2 registers the selected result and the flags
    alu_result_stage result_i (
        .clk             (clk),
        .reset           (reset),
        .unit            (unit_bus.result),
        .arith_res       (arith_res),
        .shift_logic_res (shift_logic_res),
        .result          (result),
        .flag_c_n        (flag_c_n),
        .flag_z_n        (flag_z_n),
        .flag_n_n        (flag_n_n),
        .flag_o_n        (flag_o_n),
        .flag_gt_n       (flag_gt_n),
        .flag_lt_n       (flag_lt_n),
        .flag_eq_n       (flag_eq_n),
        .flag_ne_n       (flag_ne_n)
    );

endmodule

// File: sim/alu_props.sv
/* ALU checker
   reference model of the kept opcodes, asserted against the result and flags */

`include "alu_consts.svh"

module alu_props import alu_pkg::*; (
    input logic                     clk,
    input logic                     reset,
    input logic [`ALU_WIDTH-1:0]    a,
    input logic [`ALU_WIDTH-1:0]    b,
    input logic [`ALU_OP_WIDTH-1:0] alu_op,
    input logic                     carry_in_n,
    input logic [`ALU_WIDTH-1:0]    result,
    input logic                     flag_c_n, flag_z_n, flag_n_n, flag_o_n,
    input logic                     flag_gt_n, flag_lt_n, flag_eq_n, flag_ne_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // one operation as it was presented on the top-level inputs
    typedef struct packed {
        logic [`ALU_WIDTH-1:0]    a;
        logic [`ALU_WIDTH-1:0]    b;
        logic [`ALU_OP_WIDTH-1:0] op;
        logic                     cin_n;
    } op_record_t;

    op_record_t       in_d1;
    op_record_t       in_d2;
    logic             reset_q;
    logic             settled;
    logic             signed_cmp;
    logic signed [8:0] cmp_a;
    logic signed [8:0] cmp_b;
    unit_result_t     exp;
    logic [3:0]       exp_status;
    logic [3:0]       exp_cmp;
    logic [3:0]       status;
    logic [3:0]       cmp;
    int               failures = 0;

    // value, carry and overflow worked out with plain integer arithmetic
    function automatic unit_result_t model(input logic [7:0] x, input logic [7:0] y,
                                           input logic [4:0] op, input logic cin_n);
        unit_result_t r;
        int s;
        int ss;
        int extra;
        // opcodes 13 to 15 only take the extra one while carry-in is low
        extra = (!cin_n && op >= op_a_plus_b_plus_c && op <= op_b_minus_a_minus_c) ? 1 : 0;
        s = 0;
        ss = 0;
        case (op)
            op_a:            s = x;
            op_b:            s = y;
            op_negate_a:     s = 0 - x;
            op_negate_b:     s = 0 - y;
            op_a_plus_1:     s = x + 1;
            op_b_plus_1:     s = y + 1;
            op_a_minus_1:    s = x - 1;
            op_b_minus_1:    s = y - 1;
            op_a_plus_b, op_a_plus_b_plus_c: begin
                s = x + y + extra;
                ss = $signed(x) + $signed(y) + extra;
            end
            // a subtraction of like-signed operands is never flagged as overflow
            op_a_minus_b, op_a_minus_b_signedmag, op_a_minus_b_minus_c: begin
                s = x - y - extra;
                ss = (x[7] != y[7]) ? $signed(x) - $signed(y) - extra : 0;
            end
            op_b_minus_a, op_b_minus_a_minus_c: begin
                s = y - x - extra;
                ss = (x[7] != y[7]) ? $signed(y) - $signed(x) - extra : 0;
            end
            op_a_times_b_lo: s = x * y;
            op_a_times_b_hi: s = (x * y) >> 8;
            op_a_lsl_b:      s = x << y;
            op_a_lsr_b:      s = x >> y;
            op_a_and_b:      s = x & y;
            op_a_or_b:       s = x | y;
            op_a_xor_b:      s = x ^ y;
            op_not_a:        s = x ^ 8'hff;
            op_not_b:        s = y ^ 8'hff;
            // dropped opcodes and constant zero
            default:         s = 0;
        endcase
        // anything outside one byte means a carry out or a borrow
        r.value = s[7:0];
        r.carry = (s > 255) || (s < 0);
        r.overflow = (ss > 127) || (ss < -128);
        // shifts report the last bit pushed out, and nothing once b passes 8
        if (op == op_a_lsl_b)
            r.carry = (y >= 1 && y <= 8) ? x[8 - y] : 1'b0;
        if (op == op_a_lsr_b)
            r.carry = (y >= 1 && y <= 8) ? x[y - 1] : 1'b0;
        return r;
    endfunction

    // two-deep input history with one entry per pipeline register
    always_ff @(posedge clk) begin
        reset_q <= reset;
        if (reset) begin
            in_d1 <= '0;
            in_d2 <= '0;
        end else begin
            in_d1 <= {a, b, alu_op, carry_in_n};
            in_d2 <= in_d1;
        end
    end

    // outputs follow the model once reset has been low for a full cycle
    assign settled = !reset && !reset_q;

    assign exp = model(in_d2.a, in_d2.b, in_d2.op, in_d2.cin_n);
    assign exp_status = {~exp.carry, exp.value != '0, ~exp.value[7], ~exp.overflow};
    assign status = {flag_c_n, flag_z_n, flag_n_n, flag_o_n};

    // compares use the operands and go signed only for the signed-magnitude subtract
    assign signed_cmp = (in_d2.op == op_a_minus_b_signedmag);
    assign cmp_a = signed_cmp ? {in_d2.a[7], in_d2.a} : {1'b0, in_d2.a};
    assign cmp_b = signed_cmp ? {in_d2.b[7], in_d2.b} : {1'b0, in_d2.b};
    assign exp_cmp = {!(cmp_a > cmp_b), !(cmp_a < cmp_b), cmp_a != cmp_b, cmp_a == cmp_b};
    assign cmp = {flag_gt_n, flag_lt_n, flag_eq_n, flag_ne_n};

    // reset leaves a zero result with every active-low flag high
    reset_check: assert property (@(posedge clk) reset |=> {result, status, cmp} == 16'h00ff)
        else begin
            $error("[FAIL] %0t result and flags after reset expected 00ff got %h",
                   $time, $sampled({result, status, cmp}));
            failures++;
        end

    result_check: assert property (@(posedge clk) settled |-> result == exp.value)
        else begin
            $error("[FAIL] %0t result expected %h got %h",
                   $time, $sampled(exp.value), $sampled(result));
            failures++;
        end

    status_check: assert property (@(posedge clk) settled |-> status == exp_status)
        else begin
            $error("[FAIL] %0t flag_c_n flag_z_n flag_n_n flag_o_n expected %b got %b",
                   $time, $sampled(exp_status), $sampled(status));
            failures++;
        end

    compare_check: assert property (@(posedge clk) settled |-> cmp == exp_cmp)
        else begin
            $error("[FAIL] %0t flag_gt_n flag_lt_n flag_eq_n flag_ne_n expected %b got %b",
                   $time, $sampled(exp_cmp), $sampled(cmp));
            failures++;
        end

endmodule

// File: sim/alu_tb.sv
/* ALU testbench
   random back-to-back operations into the ALU core, checked by the bound assertions */

`include "alu_consts.svh"

module alu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_ops      = 2000;
    localparam int reset_cycles = 10;
    // reset, one cycle per operation, the pipeline drain and some slack
    localparam int max_cycles   = reset_cycles + num_ops + 90;

    logic                     clk;
    logic                     reset;
    logic [`ALU_WIDTH-1:0]    a;
    logic [`ALU_WIDTH-1:0]    b;
    logic [`ALU_OP_WIDTH-1:0] alu_op;
    logic                     carry_in_n;
    logic [`ALU_WIDTH-1:0]    result;
    logic                     flag_c_n, flag_z_n, flag_n_n, flag_o_n;
    logic                     flag_gt_n, flag_lt_n, flag_eq_n, flag_ne_n;
    logic [31:0]              lfsr = 32'h51adeec7;
    int                       cycles = 0;

    alu_top dut_i (.*);

    // the checker watches the core's own ports from inside it
    bind alu_top alu_props props_i (.*);

    // one step of a 32-bit Galois LFSR with taps at 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    // n fresh bits, stepping the LFSR once for every bit taken
    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic abort_run(input string why);
        $display("test failed");
        $fatal(1, "%s", why);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // the first failing assertion ends the run
    always @(dut_i.props_i.failures) begin
        if (dut_i.props_i.failures != 0)
            abort_run("an assertion in the bound checker failed");
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles)
            abort_run("the run did not finish within the cycle limit");
    end

    initial begin
        logic [31:0] bits;
        logic        small_b;
        reset = 1'b1;
        a = '0;
        b = '0;
        alu_op = '0;
        carry_in_n = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        // a new operation every cycle keeps two of them in flight
        for (int i = 0; i < num_ops; i++) begin
            draw_bits(5, bits);
            alu_op = bits[4:0];
            draw_bits(8, bits);
            a = bits[7:0];
            // about one b in eight is pulled into 0 to 9 so the shift edges get hit
            draw_bits(3, bits);
            small_b = (bits[2:0] == 3'd0);
            draw_bits(8, bits);
            b = small_b ? bits[7:0] % 8'd10 : bits[7:0];
            draw_bits(1, bits);
            carry_in_n = bits[0];
            @(posedge clk);
            #1;
        end
        // the last operation needs two more edges plus the checking edge
        repeat (3) @(posedge clk);
        #1;
        if (dut_i.props_i.failures == 0) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run("assertions in the bound checker failed");
        end
    end

endmodule

// File: tb.f
+incdir+include
src/alu_pkg.sv
src/alu_unit_if.sv
src/alu_control.sv
src/alu_arith.sv
src/alu_shift_logic.sv
src/alu_result_stage.sv
src/alu_top.sv
sim/alu_props.sv
sim/alu_tb.sv

// File: Bender.yml
package:
  name: alu_core

export_include_dirs:
  - include

sources:
  - src/alu_pkg.sv
  - src/alu_unit_if.sv
  - src/alu_control.sv
  - src/alu_arith.sv
  - src/alu_shift_logic.sv
  - src/alu_result_stage.sv
  - src/alu_top.sv
  - target: simulation
    files:
      - sim/alu_props.sv
      - sim/alu_tb.sv
